// File: vlog.f
src/core_pkg.sv
src/core_if.sv
src/decode.sv
src/register_file.sv
src/execute.sv
src/writeback.sv
src/core_top.sv
tests/core_chk.sv
tests/core_monitor.sv
tests/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module core_tb -f vlog.f -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tests/core_tb.sv
`timescale 1ns/1ns

module core_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_RANDOM   = 2000;
    // Directed issue slots, idle cycles included, with margin
    localparam int NUM_DIRECTED = 48;
    // Each random instruction may be followed by one idle cycle
    localparam int MAX_SLOTS    = NUM_DIRECTED + 2 * NUM_RANDOM;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        rd_wr_req;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        illegal;
    int          errors;
    int          checks;

    always #(CLK_PERIOD / 2) clk = ~clk;

    core_top u_core_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rd_wr_req_o   (rd_wr_req),
        .rd_addr_o     (rd_addr),
        .rd_data_o     (rd_data),
        .illegal_o     (illegal)
    );

    core_monitor u_core_monitor (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rd_wr_req_i   (rd_wr_req),
        .rd_addr_i     (rd_addr),
        .rd_data_i     (rd_data),
        .illegal_i     (illegal),
        .errors_o      (errors),
        .checks_o      (checks)
    );

    bind execute core_chk u_core_chk (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_valid_i (dec_i.valid),
        .exe_valid_i (exe_o.valid),
        .dec_sel_i   (dec_i.rd_wrb_sel),
        .m_result_i  (exe_o.alu_m_result),
        .fb_wr_req_i (fb_i.rd_wr_req),
        .fb_addr_i   (fb_i.rd_addr)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, core_pkg::LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::JAL};
    endfunction

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= next_pc;
        next_pc      = next_pc + 32'd4;
    endtask

    // Junk on the bus while idle must be ignored
    task automatic idle_cycle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= $urandom;
    endtask

    task automatic run_directed();
        issue(i_type(12'd100, 5'd0, 3'b000, 5'd1, core_pkg::OP_IMM));
        issue(i_type(12'hFF9, 5'd0, 3'b000, 5'd2, core_pkg::OP_IMM));
        idle_cycle();
        idle_cycle();
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        issue(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        // Signed compare both ways
        issue(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd9));
        issue(u_type(20'hABCDE, 5'd10));
        idle_cycle();
        // Dependent chain through forwarding and the register file
        issue(i_type(12'd5, 5'd0, 3'b000, 5'd11, core_pkg::OP_IMM));
        issue(i_type(12'd1, 5'd11, 3'b000, 5'd11, core_pkg::OP_IMM));
        issue(r_type(7'h00, 5'd11, 5'd11, 3'b000, 5'd12));
        issue(r_type(7'h00, 5'd12, 5'd11, 3'b000, 5'd13));
        issue(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd14));
        issue(r_type(7'h01, 5'd14, 5'd14, 3'b000, 5'd15));
        issue(j_type(21'h00100, 5'd16));
        idle_cycle();
        issue(i_type(core_pkg::CSR_INSTRET, 5'd0, 3'b010, 5'd17, core_pkg::SYSTEM));
        issue(i_type(core_pkg::CSR_INSTRET, 5'd0, 3'b010, 5'd18, core_pkg::SYSTEM));
        // Writes to x0 and unsupported encodings
        issue(i_type(12'd55, 5'd0, 3'b000, 5'd0, core_pkg::OP_IMM));
        issue(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        issue(32'h0000_0000);
        issue(i_type(12'd3, 5'd1, 3'b001, 5'd20, core_pkg::OP_IMM));
        issue(i_type(12'h300, 5'd0, 3'b010, 5'd21, core_pkg::SYSTEM));
        issue(r_type(7'h01, 5'd2, 5'd1, 3'b100, 5'd22));
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd23));
        issue(i_type(core_pkg::CSR_INSTRET, 5'd0, 3'b010, 5'd24, core_pkg::SYSTEM));
        idle_cycle();
    endtask

    task automatic run_random();
        logic [31:0] word;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] csr;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            // Few registers, so hazards are frequent
            rd  = 5'($urandom % 8);
            rs1 = 5'($urandom % 8);
            csr = ($urandom % 4 == 0) ? 12'($urandom) : core_pkg::CSR_INSTRET;
            case ($urandom % 8)
                0, 1: word = r_type(($urandom % 2 == 0) ? 7'h00 : 7'($urandom % 2 * 32 + 1),
                                    5'($urandom % 8), rs1, 3'($urandom), rd);
                2: word = i_type(12'($urandom), rs1, 3'($urandom % 2), rd, core_pkg::OP_IMM);
                3: word = u_type(20'($urandom), rd);
                4: word = j_type(21'($urandom), rd);
                5: word = i_type(csr, 5'($urandom % 5 / 4), 3'b010, rd, core_pkg::SYSTEM);
                default: word = $urandom;
            endcase
            issue(word);
            if ($urandom % 4 == 0) begin
                idle_cycle();
            end
        end
    endtask

    initial begin
        #((MAX_SLOTS + 50) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence completed");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(15889));
        rst_i       = 1'b1;
        // Valid held high through reset, the stages must still stay empty
        instr_valid = 1'b1;
        instr       = $urandom;
        pc          = '0;
        next_pc     = 32'h0000_1000;
        repeat (5) @(posedge clk);
        rst_i       <= 1'b0;
        instr_valid <= 1'b0;
        run_directed();
        run_random();
        idle_cycle();
        // Two-cycle latency leaves the last result well inside this window
        repeat (3) @(posedge clk);
        @(negedge clk);
        #1;
        $display("Results checked: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : core_tb

// File: tests/core_monitor.sv
`timescale 1ns/1ns

module core_monitor (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic        rd_wr_req_i,
    input  logic [4:0]  rd_addr_i,
    input  logic [31:0] rd_data_i,
    input  logic        illegal_i,
    output int          errors_o,
    output int          checks_o
);

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        illegal;
    } result_t;

    logic [31:0] shadow [32];
    logic [31:0] retired;
    logic [1:0]  issued;
    result_t     exp_q [$];
    int          errors = 0;
    int          checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    // Architectural result of one RV32 instruction
    function automatic result_t predict(input logic [31:0] instr, input logic [31:0] pc,
                                        input logic [31:0] regs [32], input logic [31:0] count);
        result_t     res;
        logic [31:0] a;
        logic [31:0] b;
        a = regs[instr[19:15]];
        b = regs[instr[24:20]];
        res = '0;
        res.addr = instr[11:7];
        case (instr[6:0])
            core_pkg::OP: begin
                // Index is {funct7, funct3}
                case ({instr[31:25], instr[14:12]})
                    10'h000: res.data = a + b;
                    10'h100: res.data = a - b;
                    10'h007: res.data = a & b;
                    10'h006: res.data = a | b;
                    10'h004: res.data = a ^ b;
                    10'h002: res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    10'h008: res.data = a * b;
                    default: res.illegal = 1'b1;
                endcase
            end
            core_pkg::OP_IMM: begin
                res.data    = a + {{20{instr[31]}}, instr[31:20]};
                res.illegal = (instr[14:12] != 3'b000);
            end
            core_pkg::LUI:    res.data = {instr[31:12], 12'h000};
            core_pkg::JAL:    res.data = pc + 32'd4;
            core_pkg::SYSTEM: begin
                res.data    = count;
                res.illegal = !(instr[14:12] == 3'b010 && instr[19:15] == 5'd0
                                && instr[31:20] == core_pkg::CSR_INSTRET);
            end
            default: res.illegal = 1'b1;
        endcase
        res.we = !res.illegal && (res.addr != 5'd0);
        return res;
    endfunction

    // Inputs and outputs are both stable at the falling edge
    always @(negedge clk) begin
        result_t exp_r;
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
            retired = '0;
            issued  = '0;
            exp_q.delete();
        end else begin
            if (issued[1]) begin
                exp_r = exp_q.pop_front();
                checks++;
                if (exp_r.we !== rd_wr_req_i) begin
                    errors++;
                    if (exp_r.we)
                        $display("Expected write to x%0d missing at %0t", exp_r.addr, $time);
                    else
                        $display("Unexpected write to x%0d at %0t", rd_addr_i, $time);
                end else if (exp_r.we && rd_addr_i !== exp_r.addr) begin
                    errors++;
                    $display("[FAIL] rd_addr_o expected %h got %h", exp_r.addr, rd_addr_i);
                end else if (exp_r.we && rd_data_i !== exp_r.data) begin
                    errors++;
                    $display("[FAIL] rd_data_o expected %h got %h", exp_r.data, rd_data_i);
                end
                if (illegal_i !== exp_r.illegal) begin
                    errors++;
                    $display("[FAIL] illegal_o expected %h got %h", exp_r.illegal, illegal_i);
                end
            end else if (rd_wr_req_i || illegal_i) begin
                errors++;
                $display("Output active at %0t with no result due", $time);
            end
            issued = {issued[0], instr_valid_i};
            if (instr_valid_i) begin
                exp_r = predict(instr_i, pc_i, shadow, retired);
                exp_q.push_back(exp_r);
                retired = retired + 32'd1;
                if (exp_r.we) begin
                    shadow[exp_r.addr] = exp_r.data;
                end
            end
        end
    end

endmodule : core_monitor

// File: tests/core_chk.sv
`timescale 1ns/1ns

module core_chk (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             dec_valid_i,
    input  logic                             exe_valid_i,
    input  core_pkg::rd_wrb_sel_e            dec_sel_i,
    input  logic [core_pkg::XLEN-1:0]        m_result_i,
    input  logic                             fb_wr_req_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  fb_addr_i
);

    // Both stage strobes are low on the edge after a reset edge
    reset_clears_valid: assert property (@(posedge clk) rst_i |=> !dec_valid_i && !exe_valid_i)
        else $error("Stage valid set while in reset");

    // Product register holds unless a MUL passes through execute
    product_holds: assert property (@(posedge clk) disable iff (rst_i)
        !(dec_valid_i && dec_sel_i == core_pkg::RD_WRB_M_ALU) |=> $stable(m_result_i))
        else $error("Product register changed without an M_ALU instruction");

    no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        fb_wr_req_i |-> fb_addr_i != '0)
        else $error("Register write request targets x0");

endmodule : core_chk

// File: src/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             instr_valid_i,
    input  logic [31:0]                      instr_i,
    input  logic [core_pkg::XLEN-1:0]        pc_i,
    output logic                             rd_wr_req_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rd_addr_o,
    output logic [core_pkg::XLEN-1:0]        rd_data_o,
    output logic                             illegal_o
);

    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;

    dec2exe_if u_dec2exe ();
    exe2wrb_if u_exe2wrb ();
    wrb_fb_if  u_wrb_fb ();

    decode u_decode (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .dec_o         (u_dec2exe.master)
    );

    register_file u_register_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (u_wrb_fb.slave)
    );

    execute u_execute (
        .clk        (clk),
        .rst_i      (rst_i),
        .dec_i      (u_dec2exe.slave),
        .fb_i       (u_wrb_fb.slave),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exe_o      (u_exe2wrb.master)
    );

    writeback u_writeback (
        .exe_i     (u_exe2wrb.slave),
        .fb_o      (u_wrb_fb.master),
        .rd_data_o (rd_data_o),
        .illegal_o (illegal_o)
    );

    // Write port seen from outside
    assign rd_wr_req_o = u_wrb_fb.rd_wr_req;
    assign rd_addr_o   = u_wrb_fb.rd_addr;

endmodule : core_top

// File: src/writeback.sv
`timescale 1ns/1ns

module writeback (
    exe2wrb_if.slave                   exe_i,
    wrb_fb_if.master                   fb_o,
    output logic [core_pkg::XLEN-1:0]  rd_data_o,
    output logic                       illegal_o
);

    logic [core_pkg::XLEN-1:0] wrb_rd_data;

    // Destination data by writeback source
    always_comb begin
        case (exe_i.rd_wrb_sel)
            core_pkg::RD_WRB_ALU:    wrb_rd_data = exe_i.alu_result;
            core_pkg::RD_WRB_M_ALU:  wrb_rd_data = exe_i.alu_m_result;
            core_pkg::RD_WRB_INC_PC: wrb_rd_data = exe_i.pc_next;
            core_pkg::RD_WRB_CSR:    wrb_rd_data = exe_i.csr_rdata;
            default:                 wrb_rd_data = '0;
        endcase
    end

    // Feedback to the register file and the forwarding path
    assign fb_o.rd_data   = wrb_rd_data;
    assign fb_o.rd_addr   = exe_i.rd_addr;
    assign fb_o.rd_wr_req = exe_i.valid && exe_i.rd_wr_req;

    assign rd_data_o = wrb_rd_data;
    assign illegal_o = exe_i.valid && exe_i.illegal;

endmodule : writeback

// File: src/execute.sv
`timescale 1ns/1ns

module execute (
    input  logic                             clk,
    input  logic                             rst_i,
    dec2exe_if.slave                         dec_i,
    wrb_fb_if.slave                          fb_i,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    input  logic [core_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]        rs2_data_i,
    exe2wrb_if.master                        exe_o
);

    logic [core_pkg::XLEN-1:0] rs1_val;
    logic [core_pkg::XLEN-1:0] rs2_val;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_result;
    logic [core_pkg::XLEN-1:0] product;
    logic [core_pkg::XLEN-1:0] instret_q;
    logic                      m_result_we;
    logic                      csr_we;

    assign rs1_addr_o = dec_i.rs1_addr;
    assign rs2_addr_o = dec_i.rs2_addr;

    // The instruction in writeback has not reached the register file yet
    assign rs1_val = (fb_i.rd_wr_req && fb_i.rd_addr == dec_i.rs1_addr) ?
                     fb_i.rd_data : rs1_data_i;
    assign rs2_val = (fb_i.rd_wr_req && fb_i.rd_addr == dec_i.rs2_addr) ?
                     fb_i.rd_data : rs2_data_i;

    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_val;

    always_comb begin
        case (dec_i.alu_op)
            core_pkg::ADD:      alu_result = rs1_val + op_b;
            core_pkg::SUB:      alu_result = rs1_val - op_b;
            core_pkg::AND:      alu_result = rs1_val & op_b;
            core_pkg::OR:       alu_result = rs1_val | op_b;
            core_pkg::XOR:      alu_result = rs1_val ^ op_b;
            core_pkg::SLT:      alu_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
            core_pkg::PASS_IMM: alu_result = op_b;
            default:            alu_result = '0;
        endcase
    end

    // Low 32 bits of the product
    assign product = rs1_val * rs2_val;

    // Product and CSR registers only load for their own instructions
    assign m_result_we = dec_i.valid && (dec_i.rd_wrb_sel == core_pkg::RD_WRB_M_ALU);
    assign csr_we      = dec_i.valid && (dec_i.rd_wrb_sel == core_pkg::RD_WRB_CSR);

    // Counts every instruction through execute, illegal ones included
    always_ff @(posedge clk) begin
        if (rst_i) begin
            instret_q <= '0;
        end else if (dec_i.valid) begin
            instret_q <= instret_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_o.valid     <= 1'b0;
            exe_o.rd_wr_req <= 1'b0;
            exe_o.illegal   <= 1'b0;
        end else begin
            exe_o.valid     <= dec_i.valid;
            exe_o.rd_wr_req <= dec_i.valid && dec_i.rd_wr_req;
            exe_o.illegal   <= dec_i.valid && dec_i.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.valid) begin
            exe_o.rd_wrb_sel <= dec_i.rd_wrb_sel;
            exe_o.rd_addr    <= dec_i.rd_addr;
            exe_o.alu_result <= alu_result;
            exe_o.pc_next    <= dec_i.pc + 32'd4;
        end
        if (m_result_we) begin
            exe_o.alu_m_result <= product;
        end
        // Count before this instruction retires
        if (csr_we) begin
            exe_o.csr_rdata <= instret_q;
        end
    end

endmodule : execute

// File: src/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [core_pkg::XLEN-1:0]        rs1_data_o,
    output logic [core_pkg::XLEN-1:0]        rs2_data_o,
    wrb_fb_if.slave                          wr_i
);

    logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_ADDR_W];

    // Decode never requests a write to x0
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**core_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.rd_wr_req) begin
            regs[wr_i.rd_addr] <= wr_i.rd_data;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : register_file

// File: src/decode.sv
`timescale 1ns/1ns

module decode (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       instr_valid_i,
    input  logic [31:0]                instr_i,
    input  logic [core_pkg::XLEN-1:0]  pc_i,
    dec2exe_if.master                  dec_o
);

    logic [6:0]                       opcode;
    logic [2:0]                       funct3;
    logic [6:0]                       funct7;
    logic [core_pkg::REG_ADDR_W-1:0]  rs1;
    logic [core_pkg::REG_ADDR_W-1:0]  rd;
    logic [11:0]                      csr_addr;
    logic [core_pkg::XLEN-1:0]        imm_i;
    logic [core_pkg::XLEN-1:0]        imm_u;
    logic [core_pkg::XLEN-1:0]        imm_j;
    core_pkg::alu_op_e                alu_op;
    core_pkg::rd_wrb_sel_e            wrb_sel;
    logic                             use_imm;
    logic [core_pkg::XLEN-1:0]        imm;
    logic                             illegal;

    assign opcode   = instr_i[6:0];
    assign rd       = instr_i[11:7];
    assign funct3   = instr_i[14:12];
    assign rs1      = instr_i[19:15];
    assign funct7   = instr_i[31:25];
    assign csr_addr = instr_i[31:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        alu_op  = core_pkg::NONE;
        wrb_sel = core_pkg::RD_WRB_NONE;
        use_imm = 1'b0;
        imm     = '0;
        illegal = 1'b0;
        case (opcode)
            core_pkg::OP: begin
                wrb_sel = core_pkg::RD_WRB_ALU;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = core_pkg::ADD;
                    {7'b0100000, 3'b000}: alu_op = core_pkg::SUB;
                    {7'b0000000, 3'b111}: alu_op = core_pkg::AND;
                    {7'b0000000, 3'b110}: alu_op = core_pkg::OR;
                    {7'b0000000, 3'b100}: alu_op = core_pkg::XOR;
                    {7'b0000000, 3'b010}: alu_op = core_pkg::SLT;
                    // M extension, low half of the product only
                    {7'b0000001, 3'b000}: begin
                        alu_op  = core_pkg::MUL;
                        wrb_sel = core_pkg::RD_WRB_M_ALU;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            core_pkg::OP_IMM: begin
                alu_op  = core_pkg::ADD;
                wrb_sel = core_pkg::RD_WRB_ALU;
                use_imm = 1'b1;
                imm     = imm_i;
                // Only ADDI in this subset
                illegal = (funct3 != 3'b000);
            end
            core_pkg::LUI: begin
                alu_op  = core_pkg::PASS_IMM;
                wrb_sel = core_pkg::RD_WRB_ALU;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            core_pkg::JAL: begin
                wrb_sel = core_pkg::RD_WRB_INC_PC;
                imm     = imm_j;
            end
            core_pkg::SYSTEM: begin
                wrb_sel = core_pkg::RD_WRB_CSR;
                // CSRRS rd, instret, x0
                illegal = !(funct3 == 3'b010 && rs1 == '0
                            && csr_addr == core_pkg::CSR_INSTRET);
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            alu_op  = core_pkg::NONE;
            wrb_sel = core_pkg::RD_WRB_NONE;
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_o.valid     <= 1'b0;
            dec_o.rd_wr_req <= 1'b0;
            dec_o.illegal   <= 1'b0;
        end else begin
            dec_o.valid     <= instr_valid_i;
            dec_o.rd_wr_req <= instr_valid_i && !illegal && (rd != '0);
            dec_o.illegal   <= instr_valid_i && illegal;
        end
    end

    // Operation record, loaded only with a new instruction
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            dec_o.alu_op     <= alu_op;
            dec_o.rd_wrb_sel <= wrb_sel;
            dec_o.rs1_addr   <= rs1;
            dec_o.rs2_addr   <= instr_i[24:20];
            dec_o.rd_addr    <= rd;
            dec_o.use_imm    <= use_imm;
            dec_o.imm        <= imm;
            dec_o.pc         <= pc_i;
        end
    end

endmodule : decode

// File: src/core_if.sv
`timescale 1ns/1ns

// Decoded instruction record, decode to execute
interface dec2exe_if;
    logic                             valid;
    core_pkg::alu_op_e                alu_op;
    core_pkg::rd_wrb_sel_e            rd_wrb_sel;
    logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr;
    logic [core_pkg::REG_ADDR_W-1:0]  rd_addr;
    logic                             rd_wr_req;
    logic                             use_imm;
    logic [core_pkg::XLEN-1:0]        imm;
    logic [core_pkg::XLEN-1:0]        pc;
    logic                             illegal;

    modport master (output valid, alu_op, rd_wrb_sel, rs1_addr, rs2_addr, rd_addr,
                    rd_wr_req, use_imm, imm, pc, illegal);
    modport slave  (input  valid, alu_op, rd_wrb_sel, rs1_addr, rs2_addr, rd_addr,
                    rd_wr_req, use_imm, imm, pc, illegal);
endinterface : dec2exe_if

// Execute results waiting for the writeback selector
interface exe2wrb_if;
    logic                             valid;
    core_pkg::rd_wrb_sel_e            rd_wrb_sel;
    logic [core_pkg::REG_ADDR_W-1:0]  rd_addr;
    logic                             rd_wr_req;
    logic                             illegal;
    logic [core_pkg::XLEN-1:0]        alu_result;
    logic [core_pkg::XLEN-1:0]        alu_m_result;
    logic [core_pkg::XLEN-1:0]        pc_next;
    logic [core_pkg::XLEN-1:0]        csr_rdata;

    modport master (output valid, rd_wrb_sel, rd_addr, rd_wr_req, illegal,
                    alu_result, alu_m_result, pc_next, csr_rdata);
    modport slave  (input  valid, rd_wrb_sel, rd_addr, rd_wr_req, illegal,
                    alu_result, alu_m_result, pc_next, csr_rdata);
endinterface : exe2wrb_if

// Writeback feedback, register file write port and forwarding source
interface wrb_fb_if;
    logic                             rd_wr_req;
    logic [core_pkg::REG_ADDR_W-1:0]  rd_addr;
    logic [core_pkg::XLEN-1:0]        rd_data;

    modport master (output rd_wr_req, rd_addr, rd_data);
    modport slave  (input  rd_wr_req, rd_addr, rd_data);
endinterface : wrb_fb_if

// File: src/core_pkg.sv
package core_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Retire counter, read through CSRRS
    localparam logic [11:0] CSR_INSTRET = 12'hC02;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // Operation carried from decode into execute
    typedef enum logic [3:0] {
        ADD      = 4'd0,
        SUB      = 4'd1,
        AND      = 4'd2,
        OR       = 4'd3,
        XOR      = 4'd4,
        SLT      = 4'd5,
        PASS_IMM = 4'd6,
        MUL      = 4'd7,
        NONE     = 4'd8
    } alu_op_e;

    // Source of the destination register data
    typedef enum logic [2:0] {
        RD_WRB_ALU    = 3'd0,
        RD_WRB_M_ALU  = 3'd1,
        RD_WRB_INC_PC = 3'd2,
        RD_WRB_CSR    = 3'd3,
        RD_WRB_NONE   = 3'd4
    } rd_wrb_sel_e;

endpackage : core_pkg
